/* common/muldiv_config.svh */
/*
 * Multiply/divide unit configuration.
 * Datapath width and divider iteration counter width.
 */

`ifndef MULDIV_CONFIG_SVH
`define MULDIV_CONFIG_SVH

// Operand and result width in bits.
`define MULDIV_DATA_WIDTH 32

// Divider counter width, large enough to hold MULDIV_DATA_WIDTH-1.
`define MULDIV_CNT_WIDTH 6

`endif

/* common/muldiv_pkg.sv */
/*
 * Multiply/divide shared types.
 * RISC-V M-extension operation codes and front-end FSM states.
 */

package muldiv_pkg;

	// Operation code, equal to the funct3 field of the M-extension instruction.
	typedef enum logic [2:0] {
		MUL_OP    = 3'd0,  // Signed x signed, low word.
		MULH_OP   = 3'd1,  // Signed x signed, high word.
		MULHSU_OP = 3'd2,  // Signed rs1 x unsigned rs2, high word.
		MULHU_OP  = 3'd3,  // Unsigned x unsigned, high word.
		DIV_OP    = 3'd4,  // Signed quotient.
		DIVU_OP   = 3'd5,  // Unsigned quotient.
		REM_OP    = 3'd6,  // Signed remainder.
		REMU_OP   = 3'd7   // Unsigned remainder.
	} muldiv_op_e;

	// Front-end sequencing states.
	typedef enum logic [1:0] {
		IDLE_ST  = 2'd0,  // Ready for a new request.
		START_ST = 2'd1,  // Start pulse to the arithmetic unit.
		WAIT_ST  = 2'd2,  // Waiting for the divider to go idle.
		RESP_ST  = 2'd3   // Response held until taken.
	} issue_state_e;

endpackage

/* design/muldiv_issue.sv */
/*
 * Multiply/divide front end.
 * Accepts one request, sequences start and busy, buffers the response.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module muldiv_issue (
	input  logic                          clk,
	input  logic                          rstLow,
	input  logic                          req_valid_i,
	output logic                          req_ready_o,
	input  muldiv_pkg::muldiv_op_e        req_op_i,
	input  logic [`MULDIV_DATA_WIDTH-1:0] req_rs1_i,
	input  logic [`MULDIV_DATA_WIDTH-1:0] req_rs2_i,
	output logic                          rsp_valid_o,
	input  logic                          rsp_ready_i,
	output logic [`MULDIV_DATA_WIDTH-1:0] rsp_data_o,
	output muldiv_pkg::muldiv_op_e        op_o,     // Held op to the unit.
	output logic [`MULDIV_DATA_WIDTH-1:0] rs1_o,    // Held operands.
	output logic [`MULDIV_DATA_WIDTH-1:0] rs2_o,
	output logic                          start_o,  // One-cycle start.
	input  logic                          busy_i,   // Divider running.
	input  logic [`MULDIV_DATA_WIDTH-1:0] result_i  // Unit result.
);

	muldiv_pkg::issue_state_e state_q; // Current state.
	muldiv_pkg::issue_state_e state_d; // Next state.

	logic                          accept;    // Request transfers this cycle.
	logic                          done;      // Result ready to capture.
	muldiv_pkg::muldiv_op_e        op_q;
	logic [`MULDIV_DATA_WIDTH-1:0] rs1_q;
	logic [`MULDIV_DATA_WIDTH-1:0] rs2_q;
	logic [`MULDIV_DATA_WIDTH-1:0] rsp_data_q; // Response buffer.

	assign accept = req_valid_i && (state_q == muldiv_pkg::IDLE_ST);
	assign done   = (state_q == muldiv_pkg::WAIT_ST) && !busy_i;

	// Next state.
	always_comb begin
		state_d = state_q;
		case (state_q)
			muldiv_pkg::IDLE_ST:  if (accept) state_d = muldiv_pkg::START_ST;
			muldiv_pkg::START_ST: state_d = muldiv_pkg::WAIT_ST; // Single cycle.
			muldiv_pkg::WAIT_ST:  if (done) state_d = muldiv_pkg::RESP_ST;
			muldiv_pkg::RESP_ST:  if (rsp_ready_i) state_d = muldiv_pkg::IDLE_ST;
		endcase
	end

	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			state_q <= muldiv_pkg::IDLE_ST;
		end else begin
			state_q <= state_d;
		end
	end

	// Request and response payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q  <= req_op_i;
			rs1_q <= req_rs1_i;
			rs2_q <= req_rs2_i;
		end
		if (done) begin
			rsp_data_q <= result_i; // First idle cycle after start.
		end
	end

	assign req_ready_o = (state_q == muldiv_pkg::IDLE_ST);
	assign start_o     = (state_q == muldiv_pkg::START_ST);
	assign rsp_valid_o = (state_q == muldiv_pkg::RESP_ST);
	assign rsp_data_o  = rsp_data_q;
	assign op_o        = op_q;
	assign rs1_o       = rs1_q;
	assign rs2_o       = rs2_q;

endmodule

/* design/muldiv_top.sv */
/*
 * Multiply/divide top level.
 * Front end and arithmetic unit.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module muldiv_top (
	input  logic                          clk,
	input  logic                          rstLow,
	input  logic                          req_valid_i,
	output logic                          req_ready_o,
	input  muldiv_pkg::muldiv_op_e        req_op_i,
	input  logic [`MULDIV_DATA_WIDTH-1:0] req_rs1_i,
	input  logic [`MULDIV_DATA_WIDTH-1:0] req_rs2_i,
	output logic                          rsp_valid_o,
	input  logic                          rsp_ready_i,
	output logic [`MULDIV_DATA_WIDTH-1:0] rsp_data_o
);

	muldiv_pkg::muldiv_op_e        op;     // Held operation.
	logic [`MULDIV_DATA_WIDTH-1:0] rs1;    // Held operands.
	logic [`MULDIV_DATA_WIDTH-1:0] rs2;
	logic                          start;  // Start pulse.
	logic                          busy;   // Divider busy.
	logic [`MULDIV_DATA_WIDTH-1:0] result; // Unit result.

	muldiv_issue issue0 (
		.clk         (clk),
		.rstLow      (rstLow),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_op_i    (req_op_i),
		.req_rs1_i   (req_rs1_i),
		.req_rs2_i   (req_rs2_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_data_o  (rsp_data_o),
		.op_o        (op),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.start_o     (start),
		.busy_i      (busy),
		.result_i    (result)
	);

	muldiv_unit unit0 (
		.clk      (clk),
		.rstLow   (rstLow),
		.op_i     (op),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.start_i  (start),
		.busy_o   (busy),
		.result_o (result)
	);

endmodule

/* dv/muldiv_asserts.sv */
/*
 * Multiply/divide handshake assertions.
 * Response latency, back-pressure hold and reset values at the top level.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module muldiv_asserts (
	input logic                          clk,
	input logic                          rstLow,
	input logic                          req_valid_i,
	input logic                          req_ready_i, // DUT req_ready_o.
	input muldiv_pkg::muldiv_op_e        req_op_i,
	input logic [`MULDIV_DATA_WIDTH-1:0] req_rs1_i,
	input logic [`MULDIV_DATA_WIDTH-1:0] req_rs2_i,
	input logic                          rsp_valid_i, // DUT rsp_valid_o.
	input logic                          rsp_ready_i,
	input logic [`MULDIV_DATA_WIDTH-1:0] rsp_data_i   // DUT rsp_data_o.
);

	localparam int W = `MULDIV_DATA_WIDTH;

	logic                   accept;    // Request transfers this cycle.
	logic                   is_mul;    // Multiply family.
	logic                   ovf;       // Signed overflow operands.
	logic                   reuse;     // Remainder of the previous divide.
	logic                   fast;      // Divider stays idle.
	muldiv_pkg::muldiv_op_e last_op;   // Previous accepted request.
	logic [W-1:0]           last_rs1;
	logic [W-1:0]           last_rs2;
	int unsigned            lat_q;     // Cycles since acceptance.
	int unsigned            lat_exp_q; // Latency the request should see.

	assign accept = req_valid_i && req_ready_i;
	assign is_mul = (req_op_i == muldiv_pkg::MUL_OP) || (req_op_i == muldiv_pkg::MULH_OP) ||
	                (req_op_i == muldiv_pkg::MULHSU_OP) || (req_op_i == muldiv_pkg::MULHU_OP);
	assign ovf    = ((req_op_i == muldiv_pkg::DIV_OP) || (req_op_i == muldiv_pkg::REM_OP)) &&
	                (req_rs1_i == {1'b1, {(W-1){1'b0}}}) && (req_rs2_i == '1);
	// REM after DIV, REMU after DIVU, same operands.
	assign reuse  = (((req_op_i == muldiv_pkg::REM_OP) && (last_op == muldiv_pkg::DIV_OP)) ||
	                 ((req_op_i == muldiv_pkg::REMU_OP) && (last_op == muldiv_pkg::DIVU_OP))) &&
	                (req_rs1_i == last_rs1) && (req_rs2_i == last_rs2);
	assign fast   = is_mul || (req_rs2_i == '0) || ovf || reuse;

	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			last_op   <= muldiv_pkg::MUL_OP;
			last_rs1  <= '0;
			last_rs2  <= '0;
			lat_q     <= 0;
			lat_exp_q <= 0;
		end else if (accept) begin
			last_op   <= req_op_i;
			last_rs1  <= req_rs1_i;
			last_rs2  <= req_rs2_i;
			lat_q     <= 1;
			lat_exp_q <= fast ? 3 : 3 + W; // Divider adds one cycle per bit.
		end else begin
			lat_q <= lat_q + 1;
		end
	end

	//**************************************************
	// Properties
	//**************************************************
	a_latency: assert property (@(posedge clk) disable iff (!rstLow)
		$rose(rsp_valid_i) |-> (lat_q == lat_exp_q))
		else $error("response came %0d cycles after acceptance instead of %0d",
		            lat_q, lat_exp_q);

	// Stalled response keeps its data.
	a_rsp_hold: assert property (@(posedge clk) disable iff (!rstLow)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
		else $error("stalled response dropped valid or changed its data");

	a_rsp_blocks_req: assert property (@(posedge clk) disable iff (!rstLow)
		rsp_valid_i |-> !req_ready_i)
		else $error("request side ready while a response is pending");

	a_ready_after_rsp: assert property (@(posedge clk) disable iff (!rstLow)
		rsp_valid_i && rsp_ready_i |=> req_ready_i)
		else $error("request side not ready after the response transfer");

	// Reset values, checked on the first edge out of reset.
	a_reset_values: assert property (@(posedge clk)
		$rose(rstLow) |-> req_ready_i && !rsp_valid_i)
		else $error("wrong handshake outputs after reset");

endmodule

/* dv/muldiv_tb.sv */
/*
 * Multiply/divide unit testbench.
 * Corner, random and remainder-reuse requests checked against a 64-bit model.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module muldiv_tb;

	localparam int W          = `MULDIV_DATA_WIDTH;
	localparam int NUM_RAND   = 10;                      // Random requests per op.
	localparam int NUM_REUSE  = 5;                       // Rounds of divide/remainder pairs.
	localparam int NUM_OPS    = 8 * 16 + 8 * NUM_RAND + 8 * NUM_REUSE;
	localparam int MAX_CYCLES = NUM_OPS * 40 * 2;        // Longest op with margin, doubled.

	logic                   clk;
	logic                   rstLow;
	logic                   req_valid_i;
	logic                   req_ready_o;
	muldiv_pkg::muldiv_op_e req_op_i;
	logic [W-1:0]           req_rs1_i;
	logic [W-1:0]           req_rs2_i;
	logic                   rsp_valid_o;
	logic                   rsp_ready_i;
	logic [W-1:0]           rsp_data_o;

	integer       seed;      // $random state.
	logic         bp_on;     // Random stalls on the response side.
	int           cycles;
	logic [W-1:0] corner [4]; // Directed operand values.

	muldiv_top dut0 (
		.clk         (clk),
		.rstLow      (rstLow),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_op_i    (req_op_i),
		.req_rs1_i   (req_rs1_i),
		.req_rs2_i   (req_rs2_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_data_o  (rsp_data_o)
	);

	bind muldiv_top muldiv_asserts asserts0 (
		.clk (clk), .rstLow (rstLow),
		.req_valid_i (req_valid_i), .req_ready_i (req_ready_o), .req_op_i (req_op_i),
		.req_rs1_i (req_rs1_i), .req_rs2_i (req_rs2_i),
		.rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i), .rsp_data_i (rsp_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// Run limit.
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	//**************************************************
	// Reference model, RISC-V M rules in 2W-bit math
	//**************************************************
	function automatic logic [W-1:0] ref_result(input muldiv_pkg::muldiv_op_e op,
	                                            input logic [W-1:0] a, input logic [W-1:0] b);
		logic signed [2*W-1:0] sa;
		logic signed [2*W-1:0] sb;
		logic        [2*W-1:0] ua;
		logic        [2*W-1:0] ub;
		logic signed [2*W-1:0] p_ss;
		logic signed [2*W-1:0] p_su;
		logic        [2*W-1:0] p_uu;
		logic signed [2*W-1:0] q_s;
		logic signed [2*W-1:0] r_s;
		logic        [2*W-1:0] q_u;
		logic        [2*W-1:0] r_u;
		logic                  zero;
		logic                  ovf;
		logic        [W-1:0]   res;
		sa   = {{W{a[W-1]}}, a};
		sb   = {{W{b[W-1]}}, b};
		ua   = {{W{1'b0}}, a};
		ub   = {{W{1'b0}}, b};
		p_ss = sa * sb;
		p_su = sa * $signed(ub); // ub stays positive.
		p_uu = ua * ub;
		zero = (b == '0);
		ovf  = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);
		q_s  = '0;
		r_s  = '0;
		q_u  = '0;
		r_u  = '0;
		if (!zero) begin
			q_s = sa / sb; // Truncates toward zero.
			r_s = sa % sb; // Sign of the dividend.
			q_u = ua / ub;
			r_u = ua % ub;
		end
		case (op)
			muldiv_pkg::MUL_OP:    res = p_ss[W-1:0];
			muldiv_pkg::MULH_OP:   res = p_ss[2*W-1:W];
			muldiv_pkg::MULHSU_OP: res = p_su[2*W-1:W];
			muldiv_pkg::MULHU_OP:  res = p_uu[2*W-1:W];
			muldiv_pkg::DIV_OP:    res = zero ? '1 : (ovf ? a : q_s[W-1:0]);
			muldiv_pkg::DIVU_OP:   res = zero ? '1 : q_u[W-1:0];
			muldiv_pkg::REM_OP:    res = zero ? a : (ovf ? '0 : r_s[W-1:0]);
			muldiv_pkg::REMU_OP:   res = zero ? a : r_u[W-1:0];
		endcase
		return res;
	endfunction

	// Corner value three times in eight, otherwise random.
	task automatic pick_operand(output logic [W-1:0] v);
		logic [31:0] sel;
		sel = $random(seed);
		case (sel[2:0])
			3'd0:    v = corner[0];
			3'd1:    v = corner[2];
			3'd2:    v = corner[3];
			default: v = W'($random(seed));
		endcase
	endtask

	// One request in, one response out and checked.
	task automatic run_op(input muldiv_pkg::muldiv_op_e op, input logic [W-1:0] a,
	                      input logic [W-1:0] b);
		logic [W-1:0] exp;
		logic [31:0]  rnd;
		logic         got;
		exp         = ref_result(op, a, b);
		got         = 1'b0;
		req_valid_i = 1'b1;
		req_op_i    = op;
		req_rs1_i   = a;
		req_rs2_i   = b;
		while (!req_ready_o) begin
			@(negedge clk);
		end
		@(negedge clk); // Accepted on the edge just passed.
		req_valid_i = 1'b0;
		while (!got) begin
			rnd         = $random(seed);
			rsp_ready_i = bp_on ? rnd[0] : 1'b1;
			if (rsp_valid_o && rsp_ready_i) begin
				got = 1'b1; // Transfers on the next rising edge.
				assert (rsp_data_o == exp) else begin
					$display("** Error rsp_data_o expected %h actual %h (%s rs1 %h rs2 %h)",
					         exp, rsp_data_o, op.name(), a, b);
					$display("Result: FAILED");
					$fatal(1, "response data mismatch");
				end
			end
			@(negedge clk);
		end
	endtask

	//**************************************************
	// Test sequence
	//**************************************************
	initial begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		seed        = 32'hcfa0_5b77;
		bp_on       = 1'b0;
		rstLow      = 1'b0;
		req_valid_i = 1'b0;
		req_op_i    = muldiv_pkg::MUL_OP;
		req_rs1_i   = '0;
		req_rs2_i   = '0;
		rsp_ready_i = 1'b1;
		corner[0]   = '0;
		corner[1]   = {{(W-1){1'b0}}, 1'b1};
		corner[2]   = '1;
		corner[3]   = {1'b1, {(W-1){1'b0}}}; // Most negative.
		repeat (3) @(negedge clk);
		rstLow = 1'b1;

		// Every op on every corner pair, divide by zero and overflow included.
		for (int k = 0; k < 8; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					run_op(muldiv_pkg::muldiv_op_e'(3'(k)), corner[i], corner[j]);
				end
			end
		end

		bp_on = 1'b1; // Random stalls from here on.
		for (int k = 0; k < 8; k++) begin
			for (int n = 0; n < NUM_RAND; n++) begin
				pick_operand(a);
				pick_operand(b);
				run_op(muldiv_pkg::muldiv_op_e'(3'(k)), a, b);
			end
		end

		// Remainder reuse and the near misses that must divide again.
		for (int n = 0; n < NUM_REUSE; n++) begin
			a    = W'($random(seed));
			b    = W'($random(seed));
			b[0] = 1'b1; // Nonzero divisor.
			run_op(muldiv_pkg::DIV_OP, a, b);
			run_op(muldiv_pkg::REM_OP, a, b);
			run_op(muldiv_pkg::DIVU_OP, a, b);
			run_op(muldiv_pkg::REMU_OP, a, b);
			run_op(muldiv_pkg::DIVU_OP, a, b);
			run_op(muldiv_pkg::REM_OP, a, b);  // Signedness differs.
			run_op(muldiv_pkg::DIV_OP, a, b);
			run_op(muldiv_pkg::REM_OP, a, b ^ W'(2)); // Divisor changed.
		end

		@(negedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* muldiv/muldiv_unit.sv */
/*
 * M-extension arithmetic unit.
 * Combinational multiply, iterative divide, sign fix-ups,
 * special cases and remainder reuse.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module muldiv_unit (
	input  logic                          clk,
	input  logic                          rstLow,
	input  muldiv_pkg::muldiv_op_e        op_i,    // Operation select.
	input  logic [`MULDIV_DATA_WIDTH-1:0] rs1_i,   // Multiplicand or dividend.
	input  logic [`MULDIV_DATA_WIDTH-1:0] rs2_i,   // Multiplier or divisor.
	input  logic                          start_i, // One-cycle start pulse.
	output logic                          busy_o,  // Divider running.
	output logic [`MULDIV_DATA_WIDTH-1:0] result_o // Result, valid when not busy.
);

	localparam int W = `MULDIV_DATA_WIDTH;

	logic           rs1_neg;    // Sign bit of rs1.
	logic           rs2_neg;    // Sign bit of rs2.
	logic           rs1_signed; // rs1 is a signed operand.
	logic           rs2_signed; // rs2 is a signed operand.
	logic [W-1:0]   a_op;       // Magnitude or raw rs1.
	logic [W-1:0]   b_op;       // Magnitude or raw rs2.
	logic [2*W-1:0] product;    // Unsigned product.
	logic [2*W-1:0] product_ng; // Negated product.
	logic [2*W-1:0] mul_ss;     // Signed x signed product.
	logic [2*W-1:0] mul_su;     // Signed x unsigned product.
	logic [W-1:0]   div_q;      // Unsigned quotient.
	logic [W-1:0]   div_r;      // Unsigned remainder.
	logic [W-1:0]   q_fixed;    // Quotient with sign applied.
	logic [W-1:0]   r_fixed;    // Remainder with sign applied.
	logic [W-1:0]   q_out;      // Final DIV/DIVU result.
	logic [W-1:0]   r_out;      // Final REM/REMU result.
	logic           is_div;     // Any of DIV, DIVU, REM, REMU.
	logic           is_sdiv;    // Signed division, DIV or REM.
	logic           div_zero;   // Divisor is zero.
	logic           div_ovf;    // Most negative by minus one.
	logic           reuse;      // Remainder already in the divider.
	logic           div_start;  // Qualified divider start.

	muldiv_pkg::muldiv_op_e prev_op;  // Op of the previous request.
	logic [W-1:0]           prev_rs1; // Its operands.
	logic [W-1:0]           prev_rs2;

	//**************************************************
	// Operand conditioning
	//**************************************************
	assign rs1_neg = rs1_i[W-1];
	assign rs2_neg = rs2_i[W-1];

	// rs1 is signed for everything except MULHU, DIVU, REMU.
	assign rs1_signed = (op_i == muldiv_pkg::MUL_OP) || (op_i == muldiv_pkg::MULH_OP) ||
	                    (op_i == muldiv_pkg::MULHSU_OP) || (op_i == muldiv_pkg::DIV_OP) ||
	                    (op_i == muldiv_pkg::REM_OP);
	// rs2 is signed except in MULHSU and the unsigned ops.
	assign rs2_signed = (op_i == muldiv_pkg::MUL_OP) || (op_i == muldiv_pkg::MULH_OP) ||
	                    (op_i == muldiv_pkg::DIV_OP) || (op_i == muldiv_pkg::REM_OP);

	assign a_op = (rs1_signed && rs1_neg) ? (~rs1_i + 1'b1) : rs1_i; // Absolute value.
	assign b_op = (rs2_signed && rs2_neg) ? (~rs2_i + 1'b1) : rs2_i;

	//**************************************************
	// Multiplier
	//**************************************************
	assign product    = {{W{1'b0}}, a_op} * {{W{1'b0}}, b_op}; // Full 2W-bit product.
	assign product_ng = ~product + 1'b1;
	assign mul_ss     = (rs1_neg ^ rs2_neg) ? product_ng : product; // Signs differ.
	assign mul_su     = rs1_neg ? product_ng : product; // Only rs1 carries a sign.

	//**************************************************
	// Division special cases and reuse
	//**************************************************
	assign is_div   = op_i[2];
	assign is_sdiv  = (op_i == muldiv_pkg::DIV_OP) || (op_i == muldiv_pkg::REM_OP);
	assign div_zero = (rs2_i == '0);
	assign div_ovf  = (rs1_i == {1'b1, {(W-1){1'b0}}}) && (rs2_i == '1);

	// Same operands as a DIV/DIVU just done, divider already holds the remainder.
	assign reuse = (((op_i == muldiv_pkg::REM_OP) && (prev_op == muldiv_pkg::DIV_OP)) ||
	                ((op_i == muldiv_pkg::REMU_OP) && (prev_op == muldiv_pkg::DIVU_OP))) &&
	               (rs1_i == prev_rs1) && (rs2_i == prev_rs2);

	// Run the divider only when its result is really needed.
	assign div_start = start_i && is_div && !div_zero && !(is_sdiv && div_ovf) && !reuse;

	// Remember each request at its start pulse.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			prev_op <= muldiv_pkg::MUL_OP; // No reuse right after reset.
		end else if (start_i) begin
			prev_op <= op_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			prev_rs1 <= rs1_i;
			prev_rs2 <= rs2_i;
		end
	end

	restoring_divider div0 (
		.clk     (clk),
		.rstLow  (rstLow),
		.a_i     (a_op),
		.b_i     (b_op),
		.start_i (div_start),
		.q_o     (div_q),
		.r_o     (div_r),
		.busy_o  (busy_o)
	);

	//**************************************************
	// Sign fix-up and result select
	//**************************************************
	assign q_fixed = (rs1_neg ^ rs2_neg) ? (~div_q + 1'b1) : div_q; // Signs differ.
	assign r_fixed = rs1_neg ? (~div_r + 1'b1) : div_r;             // Follows the dividend.

	assign q_out = div_zero             ? '1    :  // Quotient of all ones.
	               (is_sdiv && div_ovf) ? rs1_i :  // Overflow returns the dividend.
	               is_sdiv              ? q_fixed : div_q;
	assign r_out = div_zero             ? rs1_i :  // Remainder is the dividend.
	               (is_sdiv && div_ovf) ? '0    :
	               is_sdiv              ? r_fixed : div_r;

	always_comb begin
		case (op_i)
			muldiv_pkg::MUL_OP:    result_o = mul_ss[W-1:0];
			muldiv_pkg::MULH_OP:   result_o = mul_ss[2*W-1:W];
			muldiv_pkg::MULHSU_OP: result_o = mul_su[2*W-1:W];
			muldiv_pkg::MULHU_OP:  result_o = product[2*W-1:W]; // No sign fix.
			muldiv_pkg::DIV_OP:    result_o = q_out;
			muldiv_pkg::DIVU_OP:   result_o = q_out;
			muldiv_pkg::REM_OP:    result_o = r_out;
			muldiv_pkg::REMU_OP:   result_o = r_out;
		endcase
	end

endmodule

/* muldiv/restoring_divider.sv */
/*
 * Restoring divider.
 * Unsigned iterative division, one quotient bit per clock.
 */

`timescale 1ns/1ps
`include "muldiv_config.svh"

module restoring_divider (
	input  logic                          clk,
	input  logic                          rstLow,
	input  logic [`MULDIV_DATA_WIDTH-1:0] a_i,     // Dividend.
	input  logic [`MULDIV_DATA_WIDTH-1:0] b_i,     // Divisor.
	input  logic                          start_i, // Load operands and begin.
	output logic [`MULDIV_DATA_WIDTH-1:0] q_o,     // Quotient.
	output logic [`MULDIV_DATA_WIDTH-1:0] r_o,     // Remainder.
	output logic                          busy_o   // High while iterating.
);

	localparam int W = `MULDIV_DATA_WIDTH;

	logic                         busy_q;    // Iteration in progress.
	logic [`MULDIV_CNT_WIDTH-1:0] cnt_q;     // Iterations still to go, minus one.
	logic [W-1:0]                 quo_q;     // Dividend shifts out, quotient shifts in.
	logic [W-1:0]                 rem_q;     // Partial remainder.
	logic [W-1:0]                 dvs_q;     // Held divisor.
	logic [W:0]                   rem_shift; // Remainder with next dividend bit appended.
	logic [W:0]                   rem_diff;  // Trial subtraction.

	// Partial remainder stays below the divisor, so one extra bit is enough.
	assign rem_shift = {rem_q, quo_q[W-1]};
	assign rem_diff  = rem_shift - {1'b0, dvs_q};

	// Control. Busy rises on the start edge and lasts W cycles.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (start_i && !busy_q) begin
			busy_q <= 1'b1;
			cnt_q  <= `MULDIV_CNT_WIDTH'(W - 1); // W iterations.
		end else if (busy_q) begin
			if (cnt_q == '0) begin
				busy_q <= 1'b0; // Last bit done.
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// Datapath. Values hold after completion.
	always_ff @(posedge clk) begin
		if (start_i && !busy_q) begin
			quo_q <= a_i;
			rem_q <= '0;
			dvs_q <= b_i;
		end else if (busy_q) begin
			if (rem_diff[W]) begin
				// Negative trial, restore the shifted remainder.
				rem_q <= rem_shift[W-1:0];
				quo_q <= {quo_q[W-2:0], 1'b0};
			end else begin
				rem_q <= rem_diff[W-1:0];
				quo_q <= {quo_q[W-2:0], 1'b1};
			end
		end
	end

	assign q_o    = quo_q;
	assign r_o    = rem_q;
	assign busy_o = busy_q;

endmodule

/* muldiv_top.f */
+incdir+common
common/muldiv_pkg.sv
muldiv/restoring_divider.sv
muldiv/muldiv_unit.sv
design/muldiv_issue.sv
design/muldiv_top.sv
dv/muldiv_asserts.sv
dv/muldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the muldiv testbench with Verilator, then checks the log.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb -f muldiv_top.f -o muldiv_sim &&
./obj_dir/muldiv_sim 2>&1 | tee sim.log &&
grep -q "^Result: PASSED$" sim.log &&
echo "muldiv simulation passed" ||
{ echo "muldiv simulation failed"; exit 1; }
